// File: common/up_bus_pkg.sv
/*
 * shared widths and codes for the AXI4-Lite side and the internal up bus
 * data is fixed at 32 bits and every response is OKAY
 * timeout_default must stay above the slowest register ack
 */

package up_bus_pkg;

  // ************************************************************
  // widths

  // AXI and internal bus data
  localparam int axi_data_w = 32;

  // byte address width on the AXI side
  localparam int axi_addr_w_default = 32;

  // ************************************************************
  // responses and timeout

  localparam logic [1:0] resp_okay = 2'b00;

  // cycles a request may wait before the bridge forces completion
  localparam int timeout_default = 15;

  // ************************************************************
  // bridge channel FSM

  typedef enum logic [1:0] {
    chan_idle,
    chan_req,
    chan_wait,
    chan_resp
  } chan_state_e;

endpackage

// File: common/up_reg_pkg.sv
/*
 * register map of the up register bank, in word offsets
 * offsets beyond reg_sel_w bits are unmapped and never acknowledged
 * slow_delay_default must be at least 2 and below the bridge timeout
 */

package up_reg_pkg;

  // ************************************************************
  // register map

  localparam int reg_sel_w = 8;

  typedef enum logic [reg_sel_w-1:0] {
    reg_id      = 8'h00,
    reg_scratch = 8'h01,
    reg_wcount  = 8'h02,
    reg_ctrl    = 8'h03,
    reg_slow    = 8'h04
  } reg_sel_e;

  // ************************************************************
  // constants

  // read-only identification word
  localparam logic [31:0] reg_id_value = 32'h7570_0100;

  // returned by the bridge when a read is never acknowledged
  localparam logic [31:0] timeout_rdata = 32'hdead_dead;

  // ack delay of the slow region, in cycles
  localparam int slow_delay_default = 6;

endpackage

// File: rtl/up_regbank.sv
/*
 * register bank on the up bus, word addressed
 * mapped offsets ack one cycle after the request, the slow one after ACK_DELAY
 * unmapped offsets never ack, the bridge timeout completes them
 * ACK_DELAY must be at least 2
 */

module up_regbank #(
  parameter int ADDRESS_WIDTH = 14,
  parameter int ACK_DELAY     = up_reg_pkg::slow_delay_default
) (
  input  logic                              up_clk,
  input  logic                              up_rstn,
  input  logic                              up_wreq,
  input  logic [ADDRESS_WIDTH-1:0]          up_waddr,
  input  logic [up_bus_pkg::axi_data_w-1:0] up_wdata,
  output logic                              up_wack,
  input  logic                              up_rreq,
  input  logic [ADDRESS_WIDTH-1:0]          up_raddr,
  output logic                              up_rack,
  output logic [up_bus_pkg::axi_data_w-1:0] up_rdata
);

  localparam int cnt_w = $clog2(ACK_DELAY + 1);
  localparam logic [ADDRESS_WIDTH-1:0] addr_id      = ADDRESS_WIDTH'(up_reg_pkg::reg_id);
  localparam logic [ADDRESS_WIDTH-1:0] addr_scratch = ADDRESS_WIDTH'(up_reg_pkg::reg_scratch);
  localparam logic [ADDRESS_WIDTH-1:0] addr_wcount  = ADDRESS_WIDTH'(up_reg_pkg::reg_wcount);
  localparam logic [ADDRESS_WIDTH-1:0] addr_ctrl    = ADDRESS_WIDTH'(up_reg_pkg::reg_ctrl);
  localparam logic [ADDRESS_WIDTH-1:0] addr_slow    = ADDRESS_WIDTH'(up_reg_pkg::reg_slow);

  logic [up_bus_pkg::axi_data_w-1:0] scratch;
  logic [up_bus_pkg::axi_data_w-1:0] ctrl;
  logic [up_bus_pkg::axi_data_w-1:0] slow;
  logic [up_bus_pkg::axi_data_w-1:0] wcount;
  logic                              w_fast_hit;
  logic                              r_fast_hit;
  logic                              w_slow_busy;
  logic                              r_slow_busy;
  logic [cnt_w-1:0]                  w_slow_cnt;
  logic [cnt_w-1:0]                  r_slow_cnt;
  logic                              w_slow_done;
  logic                              r_slow_done;

  // single-cycle registers
  assign w_fast_hit = up_wreq & ((up_waddr == addr_id) | (up_waddr == addr_scratch) |
                                 (up_waddr == addr_wcount) | (up_waddr == addr_ctrl));
  assign r_fast_hit = up_rreq & ((up_raddr == addr_id) | (up_raddr == addr_scratch) |
                                 (up_raddr == addr_wcount) | (up_raddr == addr_ctrl));

  assign w_slow_done = w_slow_busy & (w_slow_cnt == cnt_w'(1));
  assign r_slow_done = r_slow_busy & (r_slow_cnt == cnt_w'(1));

  // ************************************************************
  // write side

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_wack     <= 1'b0;
      scratch     <= '0;
      ctrl        <= '0;
      slow        <= '0;
      wcount      <= '0;
      w_slow_busy <= 1'b0;
      w_slow_cnt  <= '0;
    end else begin
      up_wack <= w_fast_hit | w_slow_done;
      // every acked write counts, wraps naturally
      if (up_wack == 1'b1) begin
        wcount <= wcount + 1'b1;
      end
      if (up_wreq == 1'b1) begin
        case (up_waddr)
          addr_scratch: scratch <= up_wdata;
          addr_ctrl:    ctrl <= up_wdata;
          addr_slow:    slow <= up_wdata;
          default:      ;
        endcase
      end
      if ((up_wreq == 1'b1) && (up_waddr == addr_slow)) begin
        w_slow_busy <= 1'b1;
        w_slow_cnt  <= cnt_w'(ACK_DELAY - 1);
      end else if (w_slow_busy == 1'b1) begin
        w_slow_busy <= ~w_slow_done;
        w_slow_cnt  <= w_slow_cnt - 1'b1;
      end
    end
  end

  // ************************************************************
  // read side

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_rack     <= 1'b0;
      r_slow_busy <= 1'b0;
      r_slow_cnt  <= '0;
    end else begin
      up_rack <= r_fast_hit | r_slow_done;
      if ((up_rreq == 1'b1) && (up_raddr == addr_slow)) begin
        r_slow_busy <= 1'b1;
        r_slow_cnt  <= cnt_w'(ACK_DELAY - 1);
      end else if (r_slow_busy == 1'b1) begin
        r_slow_busy <= ~r_slow_done;
        r_slow_cnt  <= r_slow_cnt - 1'b1;
      end
    end
  end

  // data lands in the same cycle as rack
  always_ff @(posedge up_clk) begin
    if (r_slow_done == 1'b1) begin
      up_rdata <= slow;
    end else if (up_rreq == 1'b1) begin
      case (up_raddr)
        addr_id:      up_rdata <= up_reg_pkg::reg_id_value;
        addr_scratch: up_rdata <= scratch;
        addr_wcount:  up_rdata <= wcount;
        addr_ctrl:    up_rdata <= ctrl;
        default:      up_rdata <= '0;
      endcase
    end
  end

  // an ack is always one cycle or ACK_DELAY cycles behind its request
  assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    up_wack |-> $past(up_wreq) || $past(up_wreq, ACK_DELAY));

  assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    up_rack |-> $past(up_rreq) || $past(up_rreq, ACK_DELAY));

endmodule

// File: rtl/up_regmap_top.sv
/*
 * up register subsystem, AXI4-Lite bridge in front of the register bank
 * all sizing and timing parameters are set here and passed down
 */

module up_regmap_top #(
  parameter int ADDRESS_WIDTH     = 14,
  parameter int AXI_ADDRESS_WIDTH = up_bus_pkg::axi_addr_w_default,
  parameter int TIMEOUT_CYCLES    = up_bus_pkg::timeout_default,
  parameter int ACK_DELAY         = up_reg_pkg::slow_delay_default
) (
  input  logic                                up_clk,
  input  logic                                up_rstn,
  input  logic                                up_axi_awvalid,
  input  logic [AXI_ADDRESS_WIDTH-1:0]        up_axi_awaddr,
  output logic                                up_axi_awready,
  input  logic                                up_axi_wvalid,
  input  logic [up_bus_pkg::axi_data_w-1:0]   up_axi_wdata,
  input  logic [up_bus_pkg::axi_data_w/8-1:0] up_axi_wstrb,
  output logic                                up_axi_wready,
  output logic                                up_axi_bvalid,
  output logic [1:0]                          up_axi_bresp,
  input  logic                                up_axi_bready,
  input  logic                                up_axi_arvalid,
  input  logic [AXI_ADDRESS_WIDTH-1:0]        up_axi_araddr,
  output logic                                up_axi_arready,
  output logic                                up_axi_rvalid,
  output logic [1:0]                          up_axi_rresp,
  output logic [up_bus_pkg::axi_data_w-1:0]   up_axi_rdata,
  input  logic                                up_axi_rready
);

  // internal register bus
  logic                              up_wreq;
  logic [ADDRESS_WIDTH-1:0]          up_waddr;
  logic [up_bus_pkg::axi_data_w-1:0] up_wdata;
  logic                              up_wack;
  logic                              up_rreq;
  logic [ADDRESS_WIDTH-1:0]          up_raddr;
  logic [up_bus_pkg::axi_data_w-1:0] up_rdata;
  logic                              up_rack;

  up_axi #(
    .ADDRESS_WIDTH     (ADDRESS_WIDTH),
    .AXI_ADDRESS_WIDTH (AXI_ADDRESS_WIDTH),
    .TIMEOUT_CYCLES    (TIMEOUT_CYCLES)
  ) i_up_axi (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_axi_awvalid (up_axi_awvalid),
    .up_axi_awaddr  (up_axi_awaddr),
    .up_axi_awready (up_axi_awready),
    .up_axi_wvalid  (up_axi_wvalid),
    .up_axi_wdata   (up_axi_wdata),
    .up_axi_wstrb   (up_axi_wstrb),
    .up_axi_wready  (up_axi_wready),
    .up_axi_bvalid  (up_axi_bvalid),
    .up_axi_bresp   (up_axi_bresp),
    .up_axi_bready  (up_axi_bready),
    .up_axi_arvalid (up_axi_arvalid),
    .up_axi_araddr  (up_axi_araddr),
    .up_axi_arready (up_axi_arready),
    .up_axi_rvalid  (up_axi_rvalid),
    .up_axi_rresp   (up_axi_rresp),
    .up_axi_rdata   (up_axi_rdata),
    .up_axi_rready  (up_axi_rready),
    .up_wreq        (up_wreq),
    .up_waddr       (up_waddr),
    .up_wdata       (up_wdata),
    .up_wack        (up_wack),
    .up_rreq        (up_rreq),
    .up_raddr       (up_raddr),
    .up_rdata       (up_rdata),
    .up_rack        (up_rack)
  );

  up_regbank #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .ACK_DELAY     (ACK_DELAY)
  ) i_up_regbank (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rack  (up_rack),
    .up_rdata (up_rdata)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the up_regmap testbench with Verilator and run it
# exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module up_regmap_tb \
  -f up_regmap.f -o up_regmap_sim || exit 1

sim_out=$(./obj_dir/up_regmap_sim 2>&1)
echo "${sim_out}"

echo "${sim_out}" | grep -qF 'All tests passed!' && exit 0 || exit 1

// File: test/up_regmap_tb.sv
/*
 * random register traffic through the AXI4-Lite port of up_regmap_top
 * one transaction at a time, so the register model here is exact
 * expected data comes from the model, never from the DUT
 */

module up_regmap_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int addr_w         = 14;
  localparam int axi_addr_w     = up_bus_pkg::axi_addr_w_default;
  localparam int data_w         = up_bus_pkg::axi_data_w;
  localparam int strb_w         = data_w / 8;
  localparam int timeout_cycles = up_bus_pkg::timeout_default;
  localparam int ack_delay      = up_reg_pkg::slow_delay_default;
  localparam int reset_cycles   = 16;
  localparam int n_random       = 300;
  // directed accesses, rounded up
  localparam int n_directed     = 24;
  localparam int run_limit      =
    (n_random + n_directed) * (timeout_cycles + 40) + reset_cycles;

  logic                  up_clk;
  logic                  up_rstn;
  logic                  up_axi_awvalid;
  logic [axi_addr_w-1:0] up_axi_awaddr;
  logic                  up_axi_awready;
  logic                  up_axi_wvalid;
  logic [data_w-1:0]     up_axi_wdata;
  logic [strb_w-1:0]     up_axi_wstrb;
  logic                  up_axi_wready;
  logic                  up_axi_bvalid;
  logic [1:0]            up_axi_bresp;
  logic                  up_axi_bready;
  logic                  up_axi_arvalid;
  logic [axi_addr_w-1:0] up_axi_araddr;
  logic                  up_axi_arready;
  logic                  up_axi_rvalid;
  logic [1:0]            up_axi_rresp;
  logic [data_w-1:0]     up_axi_rdata;
  logic                  up_axi_rready;

  logic [15:0]             lfsr_state;
  logic [data_w-1:0]       model_scratch;
  logic [data_w-1:0]       model_ctrl;
  logic [data_w-1:0]       model_slow;
  logic [data_w-1:0]       model_wcount;
  up_bus_pkg::chan_state_e w_phase;
  up_bus_pkg::chan_state_e r_phase;
  int                      error_count = 0;
  int                      cycle_count = 0;

  up_regmap_top #(
    .ADDRESS_WIDTH     (addr_w),
    .AXI_ADDRESS_WIDTH (axi_addr_w),
    .TIMEOUT_CYCLES    (timeout_cycles),
    .ACK_DELAY         (ack_delay)
  ) dut (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_axi_awvalid (up_axi_awvalid),
    .up_axi_awaddr  (up_axi_awaddr),
    .up_axi_awready (up_axi_awready),
    .up_axi_wvalid  (up_axi_wvalid),
    .up_axi_wdata   (up_axi_wdata),
    .up_axi_wstrb   (up_axi_wstrb),
    .up_axi_wready  (up_axi_wready),
    .up_axi_bvalid  (up_axi_bvalid),
    .up_axi_bresp   (up_axi_bresp),
    .up_axi_bready  (up_axi_bready),
    .up_axi_arvalid (up_axi_arvalid),
    .up_axi_araddr  (up_axi_araddr),
    .up_axi_arready (up_axi_arready),
    .up_axi_rvalid  (up_axi_rvalid),
    .up_axi_rresp   (up_axi_rresp),
    .up_axi_rdata   (up_axi_rdata),
    .up_axi_rready  (up_axi_rready)
  );

  // 4 ns clock
  always #2 up_clk = ~up_clk;

  always @(posedge up_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > run_limit) begin
      $display("run limit of %0d cycles reached, write channel %s, read channel %s",
               run_limit, w_phase.name(), r_phase.name());
      $display("Test failures found");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // ************************************************************
  // random numbers

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // mostly mapped offsets, one in sixteen lands in the hole above them
  function automatic logic [addr_w-1:0] pick_offset();
    logic [3:0] pick;
    pick = 4'(rand_bits(4));
    if (pick == 4'hf) begin
      return addr_w'(16 + int'(rand_bits(12)));
    end
    return addr_w'(int'(pick) % 5);
  endfunction

  // ************************************************************
  // register model

  function automatic logic is_mapped(input logic [addr_w-1:0] offset);
    return offset <= addr_w'(up_reg_pkg::reg_slow);
  endfunction

  function automatic void model_write(input logic [addr_w-1:0] offset,
                                      input logic [data_w-1:0] data);
    up_reg_pkg::reg_sel_e sel;
    sel = up_reg_pkg::reg_sel_e'(offset[up_reg_pkg::reg_sel_w-1:0]);
    if (is_mapped(offset)) begin
      model_wcount = model_wcount + 32'd1;
      case (sel)
        up_reg_pkg::reg_scratch: model_scratch = data;
        up_reg_pkg::reg_ctrl:    model_ctrl = data;
        up_reg_pkg::reg_slow:    model_slow = data;
        // id and wcount drop the data
        default: ;
      endcase
    end
  endfunction

  function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] offset);
    up_reg_pkg::reg_sel_e sel;
    logic [data_w-1:0]    value;
    sel   = up_reg_pkg::reg_sel_e'(offset[up_reg_pkg::reg_sel_w-1:0]);
    value = up_reg_pkg::timeout_rdata;
    if (is_mapped(offset)) begin
      case (sel)
        up_reg_pkg::reg_id:      value = up_reg_pkg::reg_id_value;
        up_reg_pkg::reg_scratch: value = model_scratch;
        up_reg_pkg::reg_wcount:  value = model_wcount;
        up_reg_pkg::reg_ctrl:    value = model_ctrl;
        default:                 value = model_slow;
      endcase
    end
    return value;
  endfunction

  // ************************************************************
  // checks

  task automatic report_error(input string what);
    $display("%0t: %s", $time, what);
    error_count++;
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] actual,
                            input logic [data_w-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s actual %h expected %h", $time, name, actual, expected);
      error_count++;
      $display("Test failures found");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s actual %b expected %b", $time, name, actual, expected);
      error_count++;
      $display("Test failures found");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // ************************************************************
  // AXI driver

  // a handshake at a posedge needs valid and ready both seen at the negedge before
  task automatic take_write_resp();
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge up_clk);
      if (up_axi_awready) report_error("awready stayed high for more than one cycle");
      if (up_axi_bvalid) begin
        w_phase = up_bus_pkg::chan_resp;
        check_resp("up_axi_bresp", up_axi_bresp, up_bus_pkg::resp_okay);
      end
      up_axi_bready = |rand_bits(2);
      accepted = up_axi_bvalid & up_axi_bready;
    end
    @(negedge up_clk);
    up_axi_bready = 1'b0;
    w_phase = up_bus_pkg::chan_idle;
    if (up_axi_bvalid) report_error("bvalid still high after the write response was taken");
  endtask

  task automatic take_read_resp(input logic [data_w-1:0] expected);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge up_clk);
      if (up_axi_arready) report_error("arready stayed high for more than one cycle");
      if (up_axi_rvalid) begin
        r_phase = up_bus_pkg::chan_resp;
        check_resp("up_axi_rresp", up_axi_rresp, up_bus_pkg::resp_okay);
        // held data must keep matching while stalled
        check_data("up_axi_rdata", up_axi_rdata, expected);
      end
      up_axi_rready = |rand_bits(2);
      accepted = up_axi_rvalid & up_axi_rready;
    end
    @(negedge up_clk);
    up_axi_rready = 1'b0;
    r_phase = up_bus_pkg::chan_idle;
    if (up_axi_rvalid) report_error("rvalid still high after the read data was taken");
  endtask

  task automatic axi_write(input logic [addr_w-1:0] offset, input logic [data_w-1:0] data);
    @(negedge up_clk);
    if (up_axi_bvalid) report_error("write response seen with no write pending");
    up_axi_awvalid = 1'b1;
    up_axi_awaddr  = axi_addr_w'({offset, 2'b00});
    up_axi_wvalid  = 1'b1;
    up_axi_wdata   = data;
    up_axi_wstrb   = strb_w'(rand_bits(strb_w));
    w_phase        = up_bus_pkg::chan_req;
    @(negedge up_clk);
    while (!up_axi_awready) begin
      if (up_axi_wready) report_error("wready pulsed without awready");
      @(negedge up_clk);
    end
    if (!up_axi_wready) report_error("awready pulsed without wready");
    up_axi_awvalid = 1'b0;
    up_axi_wvalid  = 1'b0;
    w_phase        = up_bus_pkg::chan_wait;
    take_write_resp();
    model_write(offset, data);
  endtask

  task automatic axi_read(input logic [addr_w-1:0] offset);
    logic [data_w-1:0] expected;
    expected = model_read(offset);
    @(negedge up_clk);
    if (up_axi_rvalid) report_error("read data seen with no read pending");
    up_axi_arvalid = 1'b1;
    up_axi_araddr  = axi_addr_w'({offset, 2'b00});
    r_phase        = up_bus_pkg::chan_req;
    @(negedge up_clk);
    while (!up_axi_arready) begin
      @(negedge up_clk);
    end
    up_axi_arvalid = 1'b0;
    r_phase        = up_bus_pkg::chan_wait;
    take_read_resp(expected);
  endtask

  // ************************************************************
  // test sequence

  initial begin
    logic [addr_w-1:0] offset;
    logic [data_w-1:0] data;
    int                i;
    up_clk         = 1'b0;
    up_rstn        = 1'b0;
    up_axi_awvalid = 1'b0;
    up_axi_awaddr  = '0;
    up_axi_wvalid  = 1'b0;
    up_axi_wdata   = '0;
    up_axi_wstrb   = '0;
    up_axi_bready  = 1'b0;
    up_axi_arvalid = 1'b0;
    up_axi_araddr  = '0;
    up_axi_rready  = 1'b0;
    lfsr_state     = 16'd28;
    model_scratch  = '0;
    model_ctrl     = '0;
    model_slow     = '0;
    model_wcount   = '0;
    w_phase        = up_bus_pkg::chan_idle;
    r_phase        = up_bus_pkg::chan_idle;

    repeat (reset_cycles) @(negedge up_clk);
    if (up_axi_awready || up_axi_wready || up_axi_bvalid || up_axi_arready || up_axi_rvalid)
      report_error("AXI outputs not low during reset");
    up_rstn = 1'b1;

    // reset values
    for (i = 0; i <= int'(up_reg_pkg::reg_slow); i++) begin
      axi_read(addr_w'(i));
    end

    // unmapped offsets complete through the bridge timeout
    axi_write(addr_w'(12'h123), 32'h1234_5678);
    axi_read(addr_w'(12'h123));
    axi_read(addr_w'(up_reg_pkg::reg_wcount));
    axi_read(addr_w'(up_reg_pkg::reg_scratch));

    // id is read only but the write still counts
    axi_write(addr_w'(up_reg_pkg::reg_id), 32'hffff_ffff);
    axi_read(addr_w'(up_reg_pkg::reg_id));
    axi_read(addr_w'(up_reg_pkg::reg_wcount));

    for (i = 0; i < n_random; i++) begin
      offset = pick_offset();
      if (rand_bits(1) == 32'd1) begin
        data = rand_bits(data_w);
        axi_write(offset, data);
      end else begin
        axi_read(offset);
      end
    end

    for (i = 0; i <= int'(up_reg_pkg::reg_slow); i++) begin
      axi_read(addr_w'(i));
    end

    if (error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "%0d errors counted", error_count);
    end
  end

endmodule

// File: up_axi/up_axi.sv
/*
 * AXI4-Lite slave to up register bus bridge, one write and one read in flight
 * no bursts or IDs, strobes are accepted and ignored, responses are always OKAY
 * AXI_ADDRESS_WIDTH must be at least ADDRESS_WIDTH + 2
 * a request not acked within TIMEOUT_CYCLES is forced complete
 */

module up_axi #(
  parameter int ADDRESS_WIDTH     = 14,
  parameter int AXI_ADDRESS_WIDTH = up_bus_pkg::axi_addr_w_default,
  parameter int TIMEOUT_CYCLES    = up_bus_pkg::timeout_default
) (
  // clock and reset
  input  logic                                up_clk,
  input  logic                                up_rstn,

  // axi4-lite slave
  input  logic                                up_axi_awvalid,
  input  logic [AXI_ADDRESS_WIDTH-1:0]        up_axi_awaddr,
  output logic                                up_axi_awready,
  input  logic                                up_axi_wvalid,
  input  logic [up_bus_pkg::axi_data_w-1:0]   up_axi_wdata,
  input  logic [up_bus_pkg::axi_data_w/8-1:0] up_axi_wstrb,
  output logic                                up_axi_wready,
  output logic                                up_axi_bvalid,
  output logic [1:0]                          up_axi_bresp,
  input  logic                                up_axi_bready,
  input  logic                                up_axi_arvalid,
  input  logic [AXI_ADDRESS_WIDTH-1:0]        up_axi_araddr,
  output logic                                up_axi_arready,
  output logic                                up_axi_rvalid,
  output logic [1:0]                          up_axi_rresp,
  output logic [up_bus_pkg::axi_data_w-1:0]   up_axi_rdata,
  input  logic                                up_axi_rready,

  // internal register bus
  output logic                                up_wreq,
  output logic [ADDRESS_WIDTH-1:0]            up_waddr,
  output logic [up_bus_pkg::axi_data_w-1:0]   up_wdata,
  input  logic                                up_wack,
  output logic                                up_rreq,
  output logic [ADDRESS_WIDTH-1:0]            up_raddr,
  input  logic [up_bus_pkg::axi_data_w-1:0]   up_rdata,
  input  logic                                up_rack
);

  localparam int tcnt_w = $clog2(TIMEOUT_CYCLES + 1);

  up_bus_pkg::chan_state_e           w_state;
  up_bus_pkg::chan_state_e           r_state;
  logic [tcnt_w-1:0]                 w_tcnt;
  logic [tcnt_w-1:0]                 r_tcnt;
  logic                              w_tout;
  logic                              r_tout;
  logic                              w_ack_s;
  logic                              r_ack_s;
  logic                              w_ack_d;
  logic                              r_ack_d;
  logic [up_bus_pkg::axi_data_w-1:0] r_data_s;

  assign up_axi_bresp = up_bus_pkg::resp_okay;
  assign up_axi_rresp = up_bus_pkg::resp_okay;

  // ************************************************************
  // write channel

  // a real ack wins over a coincident timeout
  assign w_tout  = (w_tcnt == tcnt_w'(TIMEOUT_CYCLES));
  assign w_ack_s = (w_state == up_bus_pkg::chan_wait) & (up_wack | w_tout);

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      w_state        <= up_bus_pkg::chan_idle;
      w_tcnt         <= '0;
      w_ack_d        <= 1'b0;
      up_wreq        <= 1'b0;
      up_axi_awready <= 1'b0;
      up_axi_wready  <= 1'b0;
      up_axi_bvalid  <= 1'b0;
    end else begin
      up_wreq        <= 1'b0;
      w_ack_d        <= w_ack_s;
      up_axi_awready <= w_ack_s;
      up_axi_wready  <= w_ack_s;
      case (w_state)
        up_bus_pkg::chan_idle: begin
          if ((up_axi_awvalid == 1'b1) && (up_axi_wvalid == 1'b1)) begin
            w_state <= up_bus_pkg::chan_req;
            up_wreq <= 1'b1;
          end
        end
        up_bus_pkg::chan_req: begin
          w_state <= up_bus_pkg::chan_wait;
          w_tcnt  <= tcnt_w'(1);
        end
        up_bus_pkg::chan_wait: begin
          if (w_ack_s == 1'b1) begin
            w_state <= up_bus_pkg::chan_resp;
          end else begin
            w_tcnt <= w_tcnt + 1'b1;
          end
        end
        default: begin
          // leave only once the response has been taken
          if ((up_axi_bvalid == 1'b1) && (up_axi_bready == 1'b1)) begin
            w_state <= up_bus_pkg::chan_idle;
          end
        end
      endcase
      if ((up_axi_bvalid == 1'b1) && (up_axi_bready == 1'b1)) begin
        up_axi_bvalid <= 1'b0;
      end else if (w_ack_d == 1'b1) begin
        up_axi_bvalid <= 1'b1;
      end
    end
  end

  // address and data follow the bus while idle, frozen once a request is out
  always_ff @(posedge up_clk) begin
    if (w_state == up_bus_pkg::chan_idle) begin
      up_waddr <= up_axi_awaddr[ADDRESS_WIDTH+1:2];
      up_wdata <= up_axi_wdata;
    end
  end

  // ************************************************************
  // read channel

  assign r_tout   = (r_tcnt == tcnt_w'(TIMEOUT_CYCLES));
  assign r_ack_s  = (r_state == up_bus_pkg::chan_wait) & (up_rack | r_tout);
  assign r_data_s = (up_rack == 1'b1) ? up_rdata : up_reg_pkg::timeout_rdata;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      r_state        <= up_bus_pkg::chan_idle;
      r_tcnt         <= '0;
      r_ack_d        <= 1'b0;
      up_rreq        <= 1'b0;
      up_axi_arready <= 1'b0;
      up_axi_rvalid  <= 1'b0;
    end else begin
      up_rreq        <= 1'b0;
      r_ack_d        <= r_ack_s;
      up_axi_arready <= r_ack_s;
      case (r_state)
        up_bus_pkg::chan_idle: begin
          if (up_axi_arvalid == 1'b1) begin
            r_state <= up_bus_pkg::chan_req;
            up_rreq <= 1'b1;
          end
        end
        up_bus_pkg::chan_req: begin
          r_state <= up_bus_pkg::chan_wait;
          r_tcnt  <= tcnt_w'(1);
        end
        up_bus_pkg::chan_wait: begin
          if (r_ack_s == 1'b1) begin
            r_state <= up_bus_pkg::chan_resp;
          end else begin
            r_tcnt <= r_tcnt + 1'b1;
          end
        end
        default: begin
          if ((up_axi_rvalid == 1'b1) && (up_axi_rready == 1'b1)) begin
            r_state <= up_bus_pkg::chan_idle;
          end
        end
      endcase
      if ((up_axi_rvalid == 1'b1) && (up_axi_rready == 1'b1)) begin
        up_axi_rvalid <= 1'b0;
      end else if (r_ack_d == 1'b1) begin
        up_axi_rvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (r_state == up_bus_pkg::chan_idle) begin
      up_raddr <= up_axi_araddr[ADDRESS_WIDTH+1:2];
    end
    // rdata loads at the ack and holds through the response
    if (r_ack_s == 1'b1) begin
      up_axi_rdata <= r_data_s;
    end
  end

  // ************************************************************
  // protocol checks

  // request strobes are single-cycle pulses
  assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    !((up_wreq && $past(up_wreq)) || (up_rreq && $past(up_rreq))));

  assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    up_axi_bvalid && !up_axi_bready |=> up_axi_bvalid);

  // no new request while that channel still owes a response
  assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    !((up_axi_bvalid && up_wreq) || (up_axi_rvalid && up_rreq)));

endmodule

// File: up_regmap.f
common/up_bus_pkg.sv
common/up_reg_pkg.sv
up_axi/up_axi.sv
rtl/up_regbank.sv
rtl/up_regmap_top.sv
test/up_regmap_tb.sv
